/* logic/wb_ic_pkg.sv */
/*
 * widths, bus structs, target ids and address regions shared by the
 * shared-bus wishbone interconnect and its sub-blocks
 */
`default_nettype none

package wb_ic_pkg;

  // --------------------------------------------------
  // bus geometry
  // --------------------------------------------------
  localparam int WB_AW = 32;
  localparam int WB_DW = 32;
  // one select bit per data byte
  localparam int WB_SW = 4;
  // three slaves, so two bits of target id
  localparam int TID_W = 2;
  localparam int NUM_MST = 3;
  localparam int NUM_SLV = 3;

  // decoders look at the top address nibble only
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 28;
  localparam int RGN_W = REGION_MSB - REGION_LSB + 1;

  typedef logic [TID_W-1:0] tid_t;
  typedef logic [RGN_W-1:0] rgn_t;

  // processor map for masters 0/1, external map for master 2
  typedef enum logic {
    MAP_RISC,
    MAP_EXT
  } wb_map_e;

  // master to slave direction, tid picks the slave port
  typedef struct packed {
    logic [WB_DW-1:0] dat;
    logic [WB_AW-1:0] adr;
    logic [WB_SW-1:0] sel;
    logic             we;
    logic             cyc;
    logic             stb;
    tid_t             tid;
  } wb_req_t;

  // slave to master direction
  typedef struct packed {
    logic [WB_DW-1:0] dat;
    logic             ack;
    logic             err;
  } wb_rsp_t;

  // --------------------------------------------------
  // slave indexes
  // --------------------------------------------------
  localparam tid_t TID_FLASH = 2'd0;
  localparam tid_t TID_SDRAM = 2'd1;
  localparam tid_t TID_GLBL  = 2'd2;

  // region nibbles, processor map
  localparam rgn_t RISC_RGN_FLASH = 4'h0;
  localparam rgn_t RISC_RGN_SPI   = 4'h1;
  localparam rgn_t RISC_RGN_SDRAM = 4'h2;
  localparam rgn_t RISC_RGN_GLBL  = 4'h3;

  // region nibbles, external map; global block sits at the same place
  localparam rgn_t EXT_RGN_FLASH = 4'h4;
  localparam rgn_t EXT_RGN_SPI   = 4'h5;
  localparam rgn_t EXT_RGN_SDRAM = 4'h6;
  localparam rgn_t EXT_RGN_GLBL  = 4'h3;

endpackage

`default_nettype wire

/* logic/wb_addr_decode.sv */
/*
 * per-master address decoder: packs the raw wishbone lines into a
 * request struct and tags it with the target slave of the chosen map
 */
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decode #(
  parameter wb_ic_pkg::wb_map_e MAP = wb_ic_pkg::MAP_RISC
) (
  input  logic [wb_ic_pkg::WB_DW-1:0] wbd_dat_i,
  input  logic [wb_ic_pkg::WB_AW-1:0] wbd_adr_i,
  input  logic [wb_ic_pkg::WB_SW-1:0] wbd_sel_i,
  input  logic                        wbd_we_i,
  input  logic                        wbd_cyc_i,
  input  logic                        wbd_stb_i,
  output wb_ic_pkg::wb_req_t          req_o
);

  import wb_ic_pkg::*;

  // region table of the selected map
  localparam rgn_t RGN_FLASH = (MAP == MAP_EXT) ? EXT_RGN_FLASH : RISC_RGN_FLASH;
  localparam rgn_t RGN_SPI   = (MAP == MAP_EXT) ? EXT_RGN_SPI   : RISC_RGN_SPI;
  localparam rgn_t RGN_SDRAM = (MAP == MAP_EXT) ? EXT_RGN_SDRAM : RISC_RGN_SDRAM;
  localparam rgn_t RGN_GLBL  = (MAP == MAP_EXT) ? EXT_RGN_GLBL  : RISC_RGN_GLBL;

  rgn_t rgn;
  tid_t tid;

  assign rgn = wbd_adr_i[REGION_MSB:REGION_LSB];

  always_comb begin
    // flash and spi registers share the flash slave port
    if ((rgn == RGN_FLASH) || (rgn == RGN_SPI)) begin
      tid = TID_FLASH;
    end else if (rgn == RGN_SDRAM) begin
      tid = TID_SDRAM;
    end else if (rgn == RGN_GLBL) begin
      tid = TID_GLBL;
    end else begin
      // unmapped space falls back to flash
      tid = TID_FLASH;
    end
  end

  assign req_o = '{dat: wbd_dat_i, adr: wbd_adr_i, sel: wbd_sel_i, we: wbd_we_i,
                   cyc: wbd_cyc_i, stb: wbd_stb_i, tid: tid};

endmodule

`default_nettype wire

/* logic/wb_rr_arbiter.sv */
/*
 * round-robin arbiter with a registered grant index; the owner keeps
 * the bus while it requests, then the next requester in order takes it
 */
`timescale 1ns/1ps
`default_nettype none

module wb_rr_arbiter #(
  parameter int NUM_REQ = 3
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [NUM_REQ-1:0]         req_i,
  output logic [$clog2(NUM_REQ)-1:0] gnt_o
);

  localparam int GNT_W = $clog2(NUM_REQ);

  logic [GNT_W-1:0] gnt_q;
  logic [GNT_W-1:0] gnt_d;

  // --------------------------------------------------
  // next grant
  // --------------------------------------------------
  always_comb begin
    int cand;
    cand  = 0;
    gnt_d = gnt_q;
    // owner still busy, keep it
    if (!req_i[gnt_q]) begin
      // walk from the farthest neighbour back to the nearest one,
      // last hit wins, so the first requester after the owner gets it
      for (int k = NUM_REQ - 1; k > 0; k--) begin
        cand = (int'(gnt_q) + k) % NUM_REQ;
        if (req_i[cand]) begin
          gnt_d = GNT_W'(cand);
        end
      end
    end
  end

  // --------------------------------------------------
  // grant register
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // master 0 owns the bus out of reset
      gnt_q <= '0;
    end else begin
      gnt_q <= gnt_d;
    end
  end

  assign gnt_o = gnt_q;

endmodule

`default_nettype wire

/* logic/wb_bus_switch.sv */
/*
 * shared-bus switch: arbitrates the masters, steers the granted request
 * to the slave named by its tid and returns that slave's reply
 */
`timescale 1ns/1ps
`default_nettype none

module wb_bus_switch #(
  parameter int NUM_MST = 3
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  wb_ic_pkg::wb_req_t [NUM_MST-1:0]            mst_req_i,
  output wb_ic_pkg::wb_rsp_t [NUM_MST-1:0]            mst_rsp_o,
  output wb_ic_pkg::wb_req_t [wb_ic_pkg::NUM_SLV-1:0] slv_req_o,
  input  wb_ic_pkg::wb_rsp_t [wb_ic_pkg::NUM_SLV-1:0] slv_rsp_i
);

  import wb_ic_pkg::*;

  localparam int GNT_W = $clog2(NUM_MST);

  logic [NUM_MST-1:0] arb_req;
  logic [GNT_W-1:0]   gnt;
  // granted request and the reply of its target
  wb_req_t            bus_req;
  wb_rsp_t            bus_rsp;

  // --------------------------------------------------
  // arbitration
  // --------------------------------------------------
  always_comb begin
    for (int m = 0; m < NUM_MST; m++) begin
      // ack closes the cycle, so drop the request in the ack cycle
      arb_req[m] = mst_req_i[m].stb & ~mst_rsp_o[m].ack;
    end
  end

  wb_rr_arbiter #(
    .NUM_REQ (NUM_MST)
  ) u_arb (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (arb_req),
    .gnt_o   (gnt)
  );

  // --------------------------------------------------
  // master side mux
  // --------------------------------------------------
  always_comb begin
    bus_req = '0;
    for (int m = 0; m < NUM_MST; m++) begin
      if (gnt == GNT_W'(m)) begin
        bus_req = mst_req_i[m];
      end
    end
  end

  // --------------------------------------------------
  // slave side steering
  // --------------------------------------------------
  always_comb begin
    // unselected slaves see an idle bus
    slv_req_o = '0;
    bus_rsp   = '0;
    for (int s = 0; s < NUM_SLV; s++) begin
      if (bus_req.tid == TID_W'(s)) begin
        slv_req_o[s] = bus_req;
        bus_rsp      = slv_rsp_i[s];
      end
    end
  end

  // reply only to the owner, the rest get zeros
  always_comb begin
    mst_rsp_o = '0;
    for (int m = 0; m < NUM_MST; m++) begin
      if (gnt == GNT_W'(m)) begin
        mst_rsp_o[m] = bus_rsp;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/wb_slave_stage.sv */
/*
 * staging register in front of one slave port: captures a request,
 * holds it until the slave answers and replays the answer for one cycle
 */
`timescale 1ns/1ps
`default_nettype none

module wb_slave_stage (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  wb_ic_pkg::wb_req_t req_i,
  output wb_ic_pkg::wb_rsp_t rsp_o,
  output wb_ic_pkg::wb_req_t s_req_o,
  input  wb_ic_pkg::wb_rsp_t s_rsp_i
);

  import wb_ic_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_REPLY
  } stg_state_e;

  stg_state_e       state_q;
  stg_state_e       state_d;
  // captured request payload
  wb_req_t          req_q;
  // slave reply, replayed toward the switch
  logic [WB_DW-1:0] rsp_dat_q;
  logic             rsp_ack_q;
  logic             rsp_err_q;
  logic             take_req;
  logic             slv_done;

  // new request only from idle
  assign take_req = (state_q == ST_IDLE) && req_i.cyc && req_i.stb;
  // slave finished the access
  assign slv_done = (state_q == ST_BUSY) && (s_rsp_i.ack || s_rsp_i.err);

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (take_req) begin
          state_d = ST_BUSY;
        end
      end
      ST_BUSY: begin
        if (slv_done) begin
          state_d = ST_REPLY;
        end
      end
      // the request still on the input is stale here, skip it
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      rsp_ack_q <= 1'b0;
      rsp_err_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      // set for exactly the reply cycle
      rsp_ack_q <= slv_done & s_rsp_i.ack;
      rsp_err_q <= slv_done & s_rsp_i.err;
    end
  end

  // --------------------------------------------------
  // payload registers
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (take_req) begin
      req_q <= req_i;
    end
    if (slv_done) begin
      rsp_dat_q <= s_rsp_i.dat;
    end
  end

  // slave side, strobes follow the busy state
  always_comb begin
    s_req_o     = req_q;
    s_req_o.cyc = (state_q == ST_BUSY);
    s_req_o.stb = (state_q == ST_BUSY);
    s_req_o.tid = '0;
  end

  assign rsp_o = '{dat: rsp_dat_q, ack: rsp_ack_q, err: rsp_err_q};

endmodule

`default_nettype wire

/* logic/wb_interconnect.sv */
/*
 * three-master, three-slave shared-bus wishbone interconnect top;
 * flat wishbone ports outside, request/response structs inside
 */
`timescale 1ns/1ps
`default_nettype none

module wb_interconnect (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // master 0, processor map
  input  logic [wb_ic_pkg::WB_DW-1:0] m0_wbd_dat_i,
  input  logic [wb_ic_pkg::WB_AW-1:0] m0_wbd_adr_i,
  input  logic [wb_ic_pkg::WB_SW-1:0] m0_wbd_sel_i,
  input  logic                        m0_wbd_we_i,
  input  logic                        m0_wbd_cyc_i,
  input  logic                        m0_wbd_stb_i,
  output logic [wb_ic_pkg::WB_DW-1:0] m0_wbd_dat_o,
  output logic                        m0_wbd_ack_o,
  output logic                        m0_wbd_err_o,

  // master 1, processor map
  input  logic [wb_ic_pkg::WB_DW-1:0] m1_wbd_dat_i,
  input  logic [wb_ic_pkg::WB_AW-1:0] m1_wbd_adr_i,
  input  logic [wb_ic_pkg::WB_SW-1:0] m1_wbd_sel_i,
  input  logic                        m1_wbd_we_i,
  input  logic                        m1_wbd_cyc_i,
  input  logic                        m1_wbd_stb_i,
  output logic [wb_ic_pkg::WB_DW-1:0] m1_wbd_dat_o,
  output logic                        m1_wbd_ack_o,
  output logic                        m1_wbd_err_o,

  // master 2, external map
  input  logic [wb_ic_pkg::WB_DW-1:0] m2_wbd_dat_i,
  input  logic [wb_ic_pkg::WB_AW-1:0] m2_wbd_adr_i,
  input  logic [wb_ic_pkg::WB_SW-1:0] m2_wbd_sel_i,
  input  logic                        m2_wbd_we_i,
  input  logic                        m2_wbd_cyc_i,
  input  logic                        m2_wbd_stb_i,
  output logic [wb_ic_pkg::WB_DW-1:0] m2_wbd_dat_o,
  output logic                        m2_wbd_ack_o,
  output logic                        m2_wbd_err_o,

  // slave 0, flash and spi registers
  input  logic [wb_ic_pkg::WB_DW-1:0] s0_wbd_dat_i,
  input  logic                        s0_wbd_ack_i,
  input  logic                        s0_wbd_err_i,
  output logic [wb_ic_pkg::WB_DW-1:0] s0_wbd_dat_o,
  output logic [wb_ic_pkg::WB_AW-1:0] s0_wbd_adr_o,
  output logic [wb_ic_pkg::WB_SW-1:0] s0_wbd_sel_o,
  output logic                        s0_wbd_we_o,
  output logic                        s0_wbd_cyc_o,
  output logic                        s0_wbd_stb_o,

  // slave 1, sdram
  input  logic [wb_ic_pkg::WB_DW-1:0] s1_wbd_dat_i,
  input  logic                        s1_wbd_ack_i,
  input  logic                        s1_wbd_err_i,
  output logic [wb_ic_pkg::WB_DW-1:0] s1_wbd_dat_o,
  output logic [wb_ic_pkg::WB_AW-1:0] s1_wbd_adr_o,
  output logic [wb_ic_pkg::WB_SW-1:0] s1_wbd_sel_o,
  output logic                        s1_wbd_we_o,
  output logic                        s1_wbd_cyc_o,
  output logic                        s1_wbd_stb_o,

  // slave 2, global registers
  input  logic [wb_ic_pkg::WB_DW-1:0] s2_wbd_dat_i,
  input  logic                        s2_wbd_ack_i,
  input  logic                        s2_wbd_err_i,
  output logic [wb_ic_pkg::WB_DW-1:0] s2_wbd_dat_o,
  output logic [wb_ic_pkg::WB_AW-1:0] s2_wbd_adr_o,
  output logic [wb_ic_pkg::WB_SW-1:0] s2_wbd_sel_o,
  output logic                        s2_wbd_we_o,
  output logic                        s2_wbd_cyc_o,
  output logic                        s2_wbd_stb_o
);

  import wb_ic_pkg::*;

  // decoded master requests and their replies
  wb_req_t [NUM_MST-1:0] mst_req;
  wb_rsp_t [NUM_MST-1:0] mst_rsp;
  // switch side of the staging registers
  wb_req_t [NUM_SLV-1:0] slv_req;
  wb_rsp_t [NUM_SLV-1:0] slv_rsp;
  // pad side of the staging registers
  wb_req_t [NUM_SLV-1:0] stg_req;
  wb_rsp_t [NUM_SLV-1:0] stg_rsp;

  // --------------------------------------------------
  // address decoders
  // --------------------------------------------------
  wb_addr_decode #(.MAP(MAP_RISC)) u_m0_dec (
    .wbd_dat_i (m0_wbd_dat_i),
    .wbd_adr_i (m0_wbd_adr_i),
    .wbd_sel_i (m0_wbd_sel_i),
    .wbd_we_i  (m0_wbd_we_i),
    .wbd_cyc_i (m0_wbd_cyc_i),
    .wbd_stb_i (m0_wbd_stb_i),
    .req_o     (mst_req[0])
  );

  wb_addr_decode #(.MAP(MAP_RISC)) u_m1_dec (
    .wbd_dat_i (m1_wbd_dat_i),
    .wbd_adr_i (m1_wbd_adr_i),
    .wbd_sel_i (m1_wbd_sel_i),
    .wbd_we_i  (m1_wbd_we_i),
    .wbd_cyc_i (m1_wbd_cyc_i),
    .wbd_stb_i (m1_wbd_stb_i),
    .req_o     (mst_req[1])
  );

  // master 2 sees the external map
  wb_addr_decode #(.MAP(MAP_EXT)) u_m2_dec (
    .wbd_dat_i (m2_wbd_dat_i),
    .wbd_adr_i (m2_wbd_adr_i),
    .wbd_sel_i (m2_wbd_sel_i),
    .wbd_we_i  (m2_wbd_we_i),
    .wbd_cyc_i (m2_wbd_cyc_i),
    .wbd_stb_i (m2_wbd_stb_i),
    .req_o     (mst_req[2])
  );

  // --------------------------------------------------
  // shared bus
  // --------------------------------------------------
  wb_bus_switch #(
    .NUM_MST (NUM_MST)
  ) u_switch (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .mst_req_i (mst_req),
    .mst_rsp_o (mst_rsp),
    .slv_req_o (slv_req),
    .slv_rsp_i (slv_rsp)
  );

  assign m0_wbd_dat_o = mst_rsp[0].dat;
  assign m0_wbd_ack_o = mst_rsp[0].ack;
  assign m0_wbd_err_o = mst_rsp[0].err;
  assign m1_wbd_dat_o = mst_rsp[1].dat;
  assign m1_wbd_ack_o = mst_rsp[1].ack;
  assign m1_wbd_err_o = mst_rsp[1].err;
  assign m2_wbd_dat_o = mst_rsp[2].dat;
  assign m2_wbd_ack_o = mst_rsp[2].ack;
  assign m2_wbd_err_o = mst_rsp[2].err;

  // --------------------------------------------------
  // staging registers, one per slave
  // --------------------------------------------------
  wb_slave_stage u_s0_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (slv_req[0]),
    .rsp_o   (slv_rsp[0]),
    .s_req_o (stg_req[0]),
    .s_rsp_i (stg_rsp[0])
  );

  wb_slave_stage u_s1_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (slv_req[1]),
    .rsp_o   (slv_rsp[1]),
    .s_req_o (stg_req[1]),
    .s_rsp_i (stg_rsp[1])
  );

  wb_slave_stage u_s2_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (slv_req[2]),
    .rsp_o   (slv_rsp[2]),
    .s_req_o (stg_req[2]),
    .s_rsp_i (stg_rsp[2])
  );

  assign stg_rsp[0] = '{dat: s0_wbd_dat_i, ack: s0_wbd_ack_i, err: s0_wbd_err_i};
  assign stg_rsp[1] = '{dat: s1_wbd_dat_i, ack: s1_wbd_ack_i, err: s1_wbd_err_i};
  assign stg_rsp[2] = '{dat: s2_wbd_dat_i, ack: s2_wbd_ack_i, err: s2_wbd_err_i};

  // tid stops at the stage, slaves only get the wishbone lines
  assign s0_wbd_dat_o = stg_req[0].dat;
  assign s0_wbd_adr_o = stg_req[0].adr;
  assign s0_wbd_sel_o = stg_req[0].sel;
  assign s0_wbd_we_o  = stg_req[0].we;
  assign s0_wbd_cyc_o = stg_req[0].cyc;
  assign s0_wbd_stb_o = stg_req[0].stb;

  assign s1_wbd_dat_o = stg_req[1].dat;
  assign s1_wbd_adr_o = stg_req[1].adr;
  assign s1_wbd_sel_o = stg_req[1].sel;
  assign s1_wbd_we_o  = stg_req[1].we;
  assign s1_wbd_cyc_o = stg_req[1].cyc;
  assign s1_wbd_stb_o = stg_req[1].stb;

  assign s2_wbd_dat_o = stg_req[2].dat;
  assign s2_wbd_adr_o = stg_req[2].adr;
  assign s2_wbd_sel_o = stg_req[2].sel;
  assign s2_wbd_we_o  = stg_req[2].we;
  assign s2_wbd_cyc_o = stg_req[2].cyc;
  assign s2_wbd_stb_o = stg_req[2].stb;

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
/*
 * testbench clock and reset source; reset is released on a falling
 * edge after the given number of clock cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* tb/tb_wb_slave_model.sv */
/*
 * behavioral wishbone slave; answers each request after 0 to 3 cycles
 * with the read data and ack or err of the matching pending master
 */
`timescale 1ns/1ps
`default_nettype none

module tb_wb_slave_model (
  input  logic        clk_i,
  input  logic        stb_i,
  input  logic [31:0] adr_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic        err_o,
  // one key per master, matched by address
  input  logic        vld_key_i [3],
  input  logic [31:0] adr_key_i [3],
  input  logic [31:0] rdat_key_i [3],
  input  int          err_key_i [3]
);

  integer seed = 90760;
  int     wait_cnt;
  logic   busy;
  logic   rerr;
  logic [31:0] rdat;

  initial begin
    dat_o <= '0;
    ack_o <= 1'b0;
    err_o <= 1'b0;
    busy  = 1'b0;
    rerr  = 1'b0;
    rdat  = '0;
    wait_cnt = 0;
  end

  // outputs change on the falling edge only
  always @(negedge clk_i) begin
    if (ack_o || err_o) begin
      // reply lasts exactly one cycle
      ack_o <= 1'b0;
      err_o <= 1'b0;
      busy = 1'b0;
    end else if (stb_i) begin
      if (!busy) begin
        busy = 1'b1;
        wait_cnt = $unsigned($random(seed)) % 4;
        rdat = 32'hdead_beef;
        rerr = 1'b0;
        for (int k = 0; k < 3; k++) begin
          if (vld_key_i[k] && (adr_key_i[k] == adr_i)) begin
            rdat = rdat_key_i[k];
            rerr = (err_key_i[k] != 0);
          end
        end
      end
      if (wait_cnt == 0) begin
        dat_o <= rdat;
        ack_o <= !rerr;
        err_o <= rerr;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_wb_interconnect.sv */
/*
 * testbench for the shared-bus interconnect; replays the transactions of
 * the data file on the three masters and checks routing, replies and order
 */
`timescale 1ns/1ps
`default_nettype none

module tb_wb_interconnect;

  localparam int MAX_LINES = 64;

  logic clk_i;
  logic rst_n;

  // master side
  logic [31:0] m_wdat [3];
  logic [31:0] m_adr [3];
  logic [3:0]  m_sel [3];
  logic        m_we [3];
  logic        m_cyc [3];
  logic        m_stb [3];
  logic [31:0] m_rdat [3];
  logic        m_ack [3];
  logic        m_err [3];

  // slave side
  logic [31:0] s_wdat [3];
  logic [31:0] s_adr [3];
  logic [3:0]  s_sel [3];
  logic        s_we [3];
  logic        s_cyc [3];
  logic        s_stb [3];
  logic [31:0] s_rdat [3];
  logic        s_ack [3];
  logic        s_err [3];

  // transaction table from the data file
  int          t_mst [MAX_LINES];
  int          t_we [MAX_LINES];
  logic [31:0] t_adr [MAX_LINES];
  logic [31:0] t_wdat [MAX_LINES];
  int          t_sel [MAX_LINES];
  logic [31:0] t_rdat [MAX_LINES];
  int          t_err [MAX_LINES];
  int          t_exp [MAX_LINES];
  int          t_grp [MAX_LINES];
  int          n_lines = 0;

  // per-master bookkeeping shared with the monitor
  logic        active [3];
  logic        started [3];
  logic        done [3];
  int          cur_line [3];
  logic [31:0] key_rdat [3];
  int          key_err [3];
  logic        stb_prev [3];
  int          slv_done_cyc [3];
  int          served [$];
  int          cycle = 0;
  int          errors = 0;

  tb_clkgen #(.PERIOD_NS(4), .RST_CYCLES(5)) u_clkgen (.clk_o(clk_i), .rst_n_o(rst_n));

  wb_interconnect DUT (
    .clk_i (clk_i), .rst_n_i (rst_n),
    .m0_wbd_dat_i (m_wdat[0]), .m0_wbd_adr_i (m_adr[0]), .m0_wbd_sel_i (m_sel[0]),
    .m0_wbd_we_i (m_we[0]), .m0_wbd_cyc_i (m_cyc[0]), .m0_wbd_stb_i (m_stb[0]),
    .m0_wbd_dat_o (m_rdat[0]), .m0_wbd_ack_o (m_ack[0]), .m0_wbd_err_o (m_err[0]),
    .m1_wbd_dat_i (m_wdat[1]), .m1_wbd_adr_i (m_adr[1]), .m1_wbd_sel_i (m_sel[1]),
    .m1_wbd_we_i (m_we[1]), .m1_wbd_cyc_i (m_cyc[1]), .m1_wbd_stb_i (m_stb[1]),
    .m1_wbd_dat_o (m_rdat[1]), .m1_wbd_ack_o (m_ack[1]), .m1_wbd_err_o (m_err[1]),
    .m2_wbd_dat_i (m_wdat[2]), .m2_wbd_adr_i (m_adr[2]), .m2_wbd_sel_i (m_sel[2]),
    .m2_wbd_we_i (m_we[2]), .m2_wbd_cyc_i (m_cyc[2]), .m2_wbd_stb_i (m_stb[2]),
    .m2_wbd_dat_o (m_rdat[2]), .m2_wbd_ack_o (m_ack[2]), .m2_wbd_err_o (m_err[2]),
    .s0_wbd_dat_i (s_rdat[0]), .s0_wbd_ack_i (s_ack[0]), .s0_wbd_err_i (s_err[0]),
    .s0_wbd_dat_o (s_wdat[0]), .s0_wbd_adr_o (s_adr[0]), .s0_wbd_sel_o (s_sel[0]),
    .s0_wbd_we_o (s_we[0]), .s0_wbd_cyc_o (s_cyc[0]), .s0_wbd_stb_o (s_stb[0]),
    .s1_wbd_dat_i (s_rdat[1]), .s1_wbd_ack_i (s_ack[1]), .s1_wbd_err_i (s_err[1]),
    .s1_wbd_dat_o (s_wdat[1]), .s1_wbd_adr_o (s_adr[1]), .s1_wbd_sel_o (s_sel[1]),
    .s1_wbd_we_o (s_we[1]), .s1_wbd_cyc_o (s_cyc[1]), .s1_wbd_stb_o (s_stb[1]),
    .s2_wbd_dat_i (s_rdat[2]), .s2_wbd_ack_i (s_ack[2]), .s2_wbd_err_i (s_err[2]),
    .s2_wbd_dat_o (s_wdat[2]), .s2_wbd_adr_o (s_adr[2]), .s2_wbd_sel_o (s_sel[2]),
    .s2_wbd_we_o (s_we[2]), .s2_wbd_cyc_o (s_cyc[2]), .s2_wbd_stb_o (s_stb[2])
  );

  for (genvar s = 0; s < 3; s++) begin : g_slv
    tb_wb_slave_model u_slv (
      .clk_i (clk_i), .stb_i (s_stb[s]), .adr_i (s_adr[s]),
      .dat_o (s_rdat[s]), .ack_o (s_ack[s]), .err_o (s_err[s]),
      .vld_key_i (active), .adr_key_i (m_adr),
      .rdat_key_i (key_rdat), .err_key_i (key_err)
    );
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR: %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // one master cycle, held until the monitor has seen the reply
  task automatic issue_txn(input int li);
    int m;
    if (li >= 0) begin
      m = t_mst[li];
      @(negedge clk_i);
      m_adr[m]    = t_adr[li];
      m_wdat[m]   = t_wdat[li];
      m_sel[m]    = t_sel[li][3:0];
      m_we[m]     = (t_we[li] != 0);
      key_rdat[m] = t_rdat[li];
      key_err[m]  = t_err[li];
      cur_line[m] = li;
      started[m]  = 1'b0;
      done[m]     = 1'b0;
      active[m]   = 1'b1;
      m_cyc[m]    = 1'b1;
      m_stb[m]    = 1'b1;
      while (!done[m]) @(negedge clk_i);
      m_cyc[m] = 1'b0;
      m_stb[m] = 1'b0;
    end
  endtask

  // --------------------------------------------------
  // monitor, samples just after the falling edge
  // --------------------------------------------------
  always @(negedge clk_i) begin
    int li;
    int hit;
    #1;
    if (rst_n) begin
      cycle++;
      for (int s = 0; s < 3; s++) begin
        if (s_stb[s] && !stb_prev[s]) begin
          hit = -1;
          for (int m = 0; m < 3; m++) begin
            if (active[m] && !started[m] && (m_adr[m] == s_adr[s])) begin
              hit = m;
            end
          end
          if (hit < 0) begin
            $display("ERROR: %0t slave %0d got a request that no master has pending",
                     $time, s);
            errors++;
          end else begin
            li = cur_line[hit];
            started[hit] = 1'b1;
            served.push_back(hit);
            check_val("slave index", t_exp[li], s);
            check_val($sformatf("s%0d_wbd_cyc_o", s), 1, 32'(s_cyc[s]));
            check_val($sformatf("s%0d_wbd_adr_o", s), t_adr[li], s_adr[s]);
            check_val($sformatf("s%0d_wbd_dat_o", s), t_wdat[li], s_wdat[s]);
            check_val($sformatf("s%0d_wbd_sel_o", s), t_sel[li], 32'(s_sel[s]));
            check_val($sformatf("s%0d_wbd_we_o", s), t_we[li], 32'(s_we[s]));
          end
        end
        if (s_ack[s] || s_err[s]) begin
          slv_done_cyc[s] = cycle;
        end
        stb_prev[s] = s_stb[s];
      end
      for (int m = 0; m < 3; m++) begin
        if (m_ack[m] || m_err[m]) begin
          if (!active[m]) begin
            $display("ERROR: %0t master %0d saw ack or err with nothing pending", $time, m);
            errors++;
          end else begin
            li = cur_line[m];
            check_val($sformatf("m%0d_wbd_err_o", m), t_err[li], 32'(m_err[m]));
            check_val($sformatf("m%0d_wbd_ack_o", m), 32'(t_err[li] == 0), 32'(m_ack[m]));
            if ((t_we[li] == 0) && (t_err[li] == 0)) begin
              check_val($sformatf("m%0d_wbd_dat_o", m), t_rdat[li], m_rdat[m]);
            end
            check_val("ack delay in cycles", 1, cycle - slv_done_cyc[t_exp[li]]);
            active[m] = 1'b0;
            done[m]   = 1'b1;
          end
        end
      end
    end
  end

  // watchdog sized from the number of transactions, all loaded before reset ends
  initial begin
    wait (rst_n);
    #((n_lines * 20 + 100) * 4);
    $display("timeout: the transactions did not complete in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int fd;
    int code;
    int i;
    int g;
    int owner;
    int err0;
    int n_tests;
    int n_failed;
    int idx_m [3];
    int exp_order [$];
    int v [9];
    string line;
    for (int m = 0; m < 3; m++) begin
      m_wdat[m] = '0;
      m_adr[m] = '0;
      m_sel[m] = '0;
      m_we[m] = 1'b0;
      m_cyc[m] = 1'b0;
      m_stb[m] = 1'b0;
      active[m] = 1'b0;
      started[m] = 1'b0;
      done[m] = 1'b0;
      cur_line[m] = 0;
      key_rdat[m] = '0;
      key_err[m] = 0;
      stb_prev[m] = 1'b0;
      slv_done_cyc[m] = 0;
    end
    n_tests = 0;
    n_failed = 0;
    fd = $fopen("tb/wb_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      while (!$feof(fd) && (n_lines < MAX_LINES)) begin
        code = $fgets(line, fd);
        if ((code > 0) && (line.len() > 1) && (line.getc(0) != "#")) begin
          code = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                         v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
          if (code == 9) begin
            t_mst[n_lines] = v[0];
            t_we[n_lines] = v[1];
            t_adr[n_lines] = v[2];
            t_wdat[n_lines] = v[3];
            t_sel[n_lines] = v[4];
            t_rdat[n_lines] = v[5];
            t_err[n_lines] = v[6];
            t_exp[n_lines] = v[7];
            t_grp[n_lines] = v[8];
            n_lines++;
          end
        end
      end
      $fclose(fd);
      if (n_lines == 0) begin
        $display("the test data file holds no transactions");
        errors++;
      end

      // reset state
      wait (rst_n);
      @(negedge clk_i);
      #1;
      err0 = errors;
      for (int k = 0; k < 3; k++) begin
        check_val($sformatf("s%0d_wbd_cyc_o", k), 0, 32'(s_cyc[k]));
        check_val($sformatf("s%0d_wbd_stb_o", k), 0, 32'(s_stb[k]));
        check_val($sformatf("m%0d_wbd_ack_o", k), 0, 32'(m_ack[k]));
        check_val($sformatf("m%0d_wbd_err_o", k), 0, 32'(m_err[k]));
      end
      n_tests++;
      n_failed += (errors != err0) ? 1 : 0;
      $display("test reset state: %s", (errors == err0) ? "ok" : "failed");

      owner = 0;
      i = 0;
      while (i < n_lines) begin
        err0 = errors;
        served.delete();
        if (t_grp[i] == 0) begin
          issue_txn(i);
          owner = t_mst[i];
          $display("test line %0d, master %0d adr %h: %s", i, t_mst[i], t_adr[i],
                   (errors == err0) ? "ok" : "failed");
          i++;
        end else begin
          g = t_grp[i];
          for (int m = 0; m < 3; m++) begin
            idx_m[m] = -1;
          end
          while ((i < n_lines) && (t_grp[i] == g)) begin
            idx_m[t_mst[i]] = i;
            i++;
          end
          // the owner keeps the grant, then the next requesters in order
          exp_order.delete();
          g = owner;
          for (int k = 0; k < 3; k++) begin
            if (idx_m[(g + k) % 3] >= 0) begin
              exp_order.push_back((g + k) % 3);
              owner = (g + k) % 3;
            end
          end
          fork
            issue_txn(idx_m[0]);
            issue_txn(idx_m[1]);
            issue_txn(idx_m[2]);
          join
          check_val("served count", exp_order.size(), served.size());
          for (int k = 0; k < exp_order.size() && k < served.size(); k++) begin
            check_val("served master", exp_order[k], served[k]);
          end
          $display("test concurrent group %0d: %s", t_grp[i - 1],
                   (errors == err0) ? "ok" : "failed");
        end
        n_tests++;
        n_failed += (errors != err0) ? 1 : 0;
      end

      $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
      if (errors == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tb/wb_testdata.txt */
# mst we adr wdat sel rdat err exp_slave group (hex; group 0 runs alone,
# lines sharing a nonzero group are issued on the same edge)
0 0 30000010 00000000 f 11110010 0 2 1
1 0 30000020 00000000 f 11110020 0 2 1
2 0 30000030 00000000 f 11110030 0 2 1
0 0 00000100 00000000 f a5a50100 0 0 0
0 1 10000004 cafe0004 3 00000000 0 0 0
1 0 20000040 00000000 f 5a5a0040 0 1 0
1 1 30000008 beef0008 c 00000000 0 2 0
0 0 70000000 00000000 f 70707070 0 0 0
2 0 40000010 00000000 f 40400010 0 0 0
2 1 50000020 12340020 1 00000000 0 0 0
2 0 60001000 00000000 f 60601000 0 1 0
2 0 00000200 00000000 f 00020002 0 0 0
1 0 20000080 00000000 f 0badbad0 1 1 0
2 1 3000000c 9876000c f 00000000 1 2 0
0 0 f0000000 00000000 f f0f0f0f0 0 0 0
0 0 20000100 00000000 f 21000100 0 1 2
1 0 20000200 00000000 f 22000200 0 1 2
2 0 60000300 00000000 f 26000300 0 1 2

/* sim.f */
logic/wb_ic_pkg.sv
logic/wb_addr_decode.sv
logic/wb_rr_arbiter.sv
logic/wb_bus_switch.sv
logic/wb_slave_stage.sv
logic/wb_interconnect.sv
tb/tb_clkgen.sv
tb/tb_wb_slave_model.sv
tb/tb_wb_interconnect.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_wb_interconnect \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Simulation finished: PASS$"; then
  exit 0
fi
exit 1
